//--- slave_ddr_defines.svh
`ifndef SLAVE_DDR_DEFINES_SVH
`define SLAVE_DDR_DEFINES_SVH

// host side, address counts 32-bit words
`define SLAVE_ADDR_W    28
`define SLAVE_DATA_W    32

// memory core side
`define CORE_DATA_W     256
`define CORE_STRB_W     32
`define LANES           8
`define MEM_DEPTH_LOG2  8

// read bridge buffering
`define RD_REQ_MAX      4
`define RD_FIFO_DEPTH   8

// write queue in wide words
`define WR_FIFO_DEPTH   4

// cycles from read grant to first data
`define CORE_RD_LAT     2

`endif

//--- slave_ddr_pkg.sv
`include "slave_ddr_defines.svh"

package slave_ddr_pkg;

    // host burst command, len+1 beats
    typedef struct packed {
        logic [`SLAVE_ADDR_W-1:0] addr;
        logic [7:0]               len;
    } host_cmd_t;

    // one wide word headed for the array
    typedef struct packed {
        logic [`MEM_DEPTH_LOG2-1:0] addr;
        logic [`CORE_DATA_W-1:0]    data;
        logic [`CORE_STRB_W-1:0]    strb; // one bit per byte
    } core_wr_t;

    // short read request, len+1 wide words
    typedef struct packed {
        logic [`MEM_DEPTH_LOG2-1:0] addr;
        logic [1:0]                 len;
    } core_rd_cmd_t;

    // wide word returned by the core
    typedef struct packed {
        logic [`CORE_DATA_W-1:0] data;
        logic                    last; // end of one core request
    } core_rd_beat_t;

endpackage

//--- sync_fifo.sv
`timescale 1ns/100ps

module sync_fifo #(
    parameter type payload_t = logic [7:0],
    parameter int  DEPTH     = 4
) (
    input  logic                       clk,
    input  logic                       rst,
    input  logic                       push,
    input  payload_t                   push_data,
    input  logic                       pop,
    output payload_t                   pop_data,
    output logic                       empty,
    output logic                       full,
    output logic [$clog2(DEPTH+1)-1:0] count
);

    localparam int PTR_W = $clog2(DEPTH);

    payload_t         mem [DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic             do_push;
    logic             do_pop;

    assign do_push  = push && !full;
    assign do_pop   = pop && !empty;
    assign empty    = (count == '0);
    assign full     = (count == ($clog2(DEPTH+1))'(DEPTH));
    assign pop_data = mem[rd_ptr]; // first word falls through

    always_ff @(posedge clk) begin
        if (do_push) begin
            mem[wr_ptr] <= push_data;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_push) begin
                wr_ptr <= (wr_ptr == PTR_W'(DEPTH-1)) ? '0 : wr_ptr + 1'b1;
            end
            if (do_pop) begin
                rd_ptr <= (rd_ptr == PTR_W'(DEPTH-1)) ? '0 : rd_ptr + 1'b1;
            end
            case ({do_push, do_pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

endmodule

//--- ddr3_write.sv
`timescale 1ns/100ps
`include "slave_ddr_defines.svh"

module ddr3_write (
    input  logic                          clk,
    input  logic                          rst,

    input  slave_ddr_pkg::host_cmd_t      wr_cmd,
    input  logic                          wr_addr_valid,
    output logic                          wr_addr_ready,

    input  logic [`SLAVE_DATA_W-1:0]      wr_data,
    input  logic [`SLAVE_DATA_W/8-1:0]    wr_strb,
    input  logic                          wr_data_valid,
    output logic                          wr_data_ready,
    input  logic                          wr_data_last,

    output slave_ddr_pkg::core_wr_t       wr_head,
    output logic                          wr_pending,
    input  logic                          wr_take,
    input  logic                          wr_idle
);

    localparam int QCNT_W = $clog2(`WR_FIFO_DEPTH+1);

    typedef enum logic [1:0] {S_IDLE, S_DATA, S_DRAIN} state_t;

    state_t                  state;
    slave_ddr_pkg::core_wr_t gather;     // word being assembled
    logic                    flush;      // push gather this cycle
    logic [2:0]              lane;
    logic [7:0]              beats_left;
    logic                    addr_hs;
    logic                    beat_hs;
    logic                    end_beat;
    logic                    q_empty;
    logic [QCNT_W-1:0]       q_count;

    assign addr_hs  = wr_addr_valid && wr_addr_ready;
    assign beat_hs  = wr_data_valid && wr_data_ready;
    assign end_beat = wr_data_last || (beats_left == 8'd0);

    assign wr_addr_ready = (state == S_IDLE);
    // leave room for a flush already on its way
    assign wr_data_ready = (state == S_DATA) &&
                           (int'(q_count) + int'(flush) < `WR_FIFO_DEPTH);
    assign wr_pending    = !q_empty;

    always_ff @(posedge clk) begin
        if (rst) begin
            state       <= S_DRAIN; // settles to idle once the core is quiet
            flush       <= 1'b0;
            lane        <= '0;
            beats_left  <= '0;
            gather.strb <= '0;
        end else begin
            flush <= 1'b0;
            if (flush) begin
                gather.strb <= '0;                  // fresh mask for next word
                gather.addr <= gather.addr + 1'b1;
            end

            case (state)
                S_IDLE: begin
                    if (addr_hs) begin
                        state       <= S_DATA;
                        lane        <= wr_cmd.addr[2:0];
                        beats_left  <= wr_cmd.len;
                        gather.addr <= wr_cmd.addr[`MEM_DEPTH_LOG2+2:3];
                        gather.strb <= '0;
                    end
                end
                S_DATA: begin
                    if (beat_hs && end_beat) begin
                        state <= S_DRAIN;
                    end
                end
                default: begin
                    if (!flush && q_empty && wr_idle) begin
                        state <= S_IDLE;
                    end
                end
            endcase

            if (beat_hs) begin
                gather.data[lane*`SLAVE_DATA_W +: `SLAVE_DATA_W]     <= wr_data;
                gather.strb[lane*`SLAVE_DATA_W/8 +: `SLAVE_DATA_W/8] <= wr_strb;
                lane       <= lane + 1'b1;
                beats_left <= beats_left - 1'b1;
                if (lane == 3'd7 || end_beat) begin
                    flush <= 1'b1;
                end
            end
        end
    end

    sync_fifo #(
        .payload_t (slave_ddr_pkg::core_wr_t),
        .DEPTH     (`WR_FIFO_DEPTH)
    ) wr_queue (
        .clk       (clk),
        .rst       (rst),
        .push      (flush),
        .push_data (gather),
        .pop       (wr_take),
        .pop_data  (wr_head),
        .empty     (q_empty),
        .full      (),
        .count     (q_count)
    );

endmodule

//--- ddr3_read.sv
`timescale 1ns/100ps
`include "slave_ddr_defines.svh"

module ddr3_read (
    input  logic                          clk,
    input  logic                          rst,

    input  slave_ddr_pkg::host_cmd_t      rd_cmd,
    input  logic                          rd_addr_valid,
    output logic                          rd_addr_ready,

    output logic [`SLAVE_DATA_W-1:0]      rd_data,
    output logic                          rd_data_last,
    output logic                          rd_data_valid,
    input  logic                          rd_data_ready,

    output slave_ddr_pkg::core_rd_cmd_t   core_cmd,
    output logic                          rd_req,
    input  logic                          rd_grant,

    input  slave_ddr_pkg::core_rd_beat_t  core_beat,
    input  logic                          rd_beat_valid
);

    localparam int FCNT_W = $clog2(`RD_FIFO_DEPTH+1);

    typedef enum logic [1:0] {S_OFF, S_IDLE, S_RUN} state_t;

    state_t                       state;
    logic [`MEM_DEPTH_LOG2-1:0]   req_addr;
    logic [5:0]                   words_left; // wide words not yet requested
    logic [2:0]                   chunk;
    logic [3:0]                   in_flight;  // granted, not yet returned
    logic [8:0]                   end_off;
    logic [2:0]                   lane;
    logic [7:0]                   beats_left;
    logic                         room;
    logic                         addr_hs;
    logic                         data_hs;
    logic                         buf_pop;
    logic                         buf_empty;
    logic [FCNT_W-1:0]            buf_count;
    slave_ddr_pkg::core_rd_beat_t buf_head;

    assign addr_hs = rd_addr_valid && rd_addr_ready;
    assign data_hs = rd_data_valid && rd_data_ready;
    assign end_off = 9'(rd_cmd.addr[2:0]) + 9'(rd_cmd.len);

    assign chunk = (words_left > 6'(`RD_REQ_MAX)) ? 3'(`RD_REQ_MAX) : words_left[2:0];
    // the core cannot be stalled, so every beat must fit on arrival
    assign room  = (int'(chunk) + int'(buf_count) + int'(in_flight)) <= `RD_FIFO_DEPTH;

    assign rd_req        = (state == S_RUN) && (words_left != '0) && room;
    assign core_cmd.addr = req_addr;
    assign core_cmd.len  = 2'(chunk - 3'd1);

    assign rd_addr_ready = (state == S_IDLE);
    assign rd_data_valid = (state == S_RUN) && !buf_empty;
    assign rd_data       = buf_head.data[lane*`SLAVE_DATA_W +: `SLAVE_DATA_W];
    assign rd_data_last  = (beats_left == 8'd0);
    assign buf_pop       = data_hs && (lane == 3'd7 || rd_data_last);

    always_ff @(posedge clk) begin
        if (rst) begin
            state      <= S_OFF;
            words_left <= '0;
            in_flight  <= '0;
            lane       <= '0;
            beats_left <= '0;
            req_addr   <= '0;
        end else begin
            in_flight <= in_flight + (rd_grant ? 4'(chunk) : 4'd0)
                                   - (rd_beat_valid ? 4'd1 : 4'd0);
            if (rd_grant) begin
                req_addr   <= req_addr + `MEM_DEPTH_LOG2'(chunk);
                words_left <= words_left - 6'(chunk);
            end

            case (state)
                S_OFF: state <= S_IDLE;
                S_IDLE: begin
                    if (addr_hs) begin
                        state      <= S_RUN;
                        lane       <= rd_cmd.addr[2:0];
                        beats_left <= rd_cmd.len;
                        req_addr   <= rd_cmd.addr[`MEM_DEPTH_LOG2+2:3];
                        words_left <= 6'(end_off >> 3) + 6'd1; // span of the burst
                    end
                end
                default: begin
                    if (data_hs) begin
                        lane       <= lane + 1'b1;
                        beats_left <= beats_left - 1'b1;
                        if (rd_data_last) begin
                            state <= S_IDLE;
                        end
                    end
                end
            endcase
        end
    end

    sync_fifo #(
        .payload_t (slave_ddr_pkg::core_rd_beat_t),
        .DEPTH     (`RD_FIFO_DEPTH)
    ) rd_buf (
        .clk       (clk),
        .rst       (rst),
        .push      (rd_beat_valid),
        .push_data (core_beat),
        .pop       (buf_pop),
        .pop_data  (buf_head),
        .empty     (buf_empty),
        .full      (),
        .count     (buf_count)
    );

endmodule

//--- ddr_mem_core.sv
`timescale 1ns/100ps
`include "slave_ddr_defines.svh"

module ddr_mem_core (
    input  logic                          clk,
    input  logic                          rst,
    output logic                          init_done,

    input  slave_ddr_pkg::core_wr_t       wr_head,
    input  logic                          wr_pending,
    output logic                          wr_take,
    output logic                          wr_idle,

    input  slave_ddr_pkg::core_rd_cmd_t   core_cmd,
    input  logic                          rd_req,
    output logic                          rd_grant,

    output slave_ddr_pkg::core_rd_beat_t  core_beat,
    output logic                          rd_beat_valid
);

    localparam int LAT = `CORE_RD_LAT;

    logic [`CORE_DATA_W-1:0]      mem [2**`MEM_DEPTH_LOG2];
    logic [`MEM_DEPTH_LOG2-1:0]   init_cnt;
    logic                         prio_rd;     // read wins the next tie
    logic                         rd_busy;     // burst still reading the array
    logic [`MEM_DEPTH_LOG2-1:0]   rd_addr;
    logic [1:0]                   rd_cnt;
    logic                         issue;
    logic [`MEM_DEPTH_LOG2-1:0]   issue_addr;
    logic                         issue_last;
    slave_ddr_pkg::core_wr_t      wr_stage;
    logic                         wr_stage_valid;
    slave_ddr_pkg::core_rd_beat_t pipe [LAT];
    logic [LAT-1:0]               pipe_valid;

    assign wr_take  = init_done && !rd_busy && wr_pending && (!rd_req || !prio_rd);
    assign rd_grant = init_done && !rd_busy && rd_req && (!wr_pending || prio_rd);
    assign wr_idle  = !wr_stage_valid;

    assign issue      = rd_grant || rd_busy;
    assign issue_addr = rd_grant ? core_cmd.addr : rd_addr;
    assign issue_last = rd_grant ? (core_cmd.len == 2'd0) : (rd_cnt == 2'd0);

    assign core_beat     = pipe[LAT-1];
    assign rd_beat_valid = pipe_valid[LAT-1];

    always_ff @(posedge clk) begin
        if (rst) begin
            init_cnt       <= '0;
            init_done      <= 1'b0;
            prio_rd        <= 1'b0;
            rd_busy        <= 1'b0;
            rd_cnt         <= '0;
            wr_stage_valid <= 1'b0;
            pipe_valid     <= '0;
        end else begin
            if (!init_done) begin
                init_cnt <= init_cnt + 1'b1;
                if (init_cnt == '1) begin
                    init_done <= 1'b1; // whole array swept to zero
                end
            end
            if (wr_take) begin
                prio_rd <= 1'b1;
            end else if (rd_grant) begin
                prio_rd <= 1'b0;
            end
            if (rd_grant) begin
                rd_busy <= (core_cmd.len != 2'd0);
                rd_addr <= core_cmd.addr + 1'b1;
                rd_cnt  <= core_cmd.len - 1'b1;
            end else if (rd_busy) begin
                rd_busy <= (rd_cnt != 2'd0);
                rd_addr <= rd_addr + 1'b1;
                rd_cnt  <= rd_cnt - 1'b1;
            end
            wr_stage_valid <= wr_take;
            pipe_valid     <= {pipe_valid[LAT-2:0], issue};
        end
    end

    // array write port, sweep first and then masked writes
    always_ff @(posedge clk) begin
        if (!init_done) begin
            mem[init_cnt] <= '0;
        end else if (wr_stage_valid) begin
            for (int i = 0; i < `CORE_STRB_W; i++) begin
                if (wr_stage.strb[i]) begin
                    mem[wr_stage.addr][8*i +: 8] <= wr_stage.data[8*i +: 8];
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (wr_take) begin
            wr_stage <= wr_head;
        end
        pipe[0].data <= mem[issue_addr];
        pipe[0].last <= issue_last;
        for (int k = 1; k < LAT; k++) begin
            pipe[k] <= pipe[k-1]; // fixed latency delay line
        end
    end

endmodule

//--- slave_ddr3.sv
`timescale 1ns/100ps
`include "slave_ddr_defines.svh"

module slave_ddr3 (
    input  logic                          clk,
    input  logic                          rst,
    output logic                          init_done,

    input  slave_ddr_pkg::host_cmd_t      wr_cmd,
    input  logic                          wr_addr_valid,
    output logic                          wr_addr_ready,
    input  logic [`SLAVE_DATA_W-1:0]      wr_data,
    input  logic [`SLAVE_DATA_W/8-1:0]    wr_strb,
    input  logic                          wr_data_valid,
    output logic                          wr_data_ready,
    input  logic                          wr_data_last,

    input  slave_ddr_pkg::host_cmd_t      rd_cmd,
    input  logic                          rd_addr_valid,
    output logic                          rd_addr_ready,
    output logic [`SLAVE_DATA_W-1:0]      rd_data,
    output logic                          rd_data_last,
    output logic                          rd_data_valid,
    input  logic                          rd_data_ready
);

    slave_ddr_pkg::core_wr_t      wr_head;
    slave_ddr_pkg::core_rd_cmd_t  core_cmd;
    slave_ddr_pkg::core_rd_beat_t core_beat;
    logic                         bridge_rst;
    logic                         wr_pending;
    logic                         wr_take;
    logic                         wr_idle;
    logic                         rd_req;
    logic                         rd_grant;
    logic                         rd_beat_valid;

    assign bridge_rst = rst || !init_done; // host side waits for the sweep

    ddr3_write u_write (
        .clk           (clk),
        .rst           (bridge_rst),
        .wr_cmd        (wr_cmd),
        .wr_addr_valid (wr_addr_valid),
        .wr_addr_ready (wr_addr_ready),
        .wr_data       (wr_data),
        .wr_strb       (wr_strb),
        .wr_data_valid (wr_data_valid),
        .wr_data_ready (wr_data_ready),
        .wr_data_last  (wr_data_last),
        .wr_head       (wr_head),
        .wr_pending    (wr_pending),
        .wr_take       (wr_take),
        .wr_idle       (wr_idle)
    );

    ddr3_read u_read (
        .clk           (clk),
        .rst           (bridge_rst),
        .rd_cmd        (rd_cmd),
        .rd_addr_valid (rd_addr_valid),
        .rd_addr_ready (rd_addr_ready),
        .rd_data       (rd_data),
        .rd_data_last  (rd_data_last),
        .rd_data_valid (rd_data_valid),
        .rd_data_ready (rd_data_ready),
        .core_cmd      (core_cmd),
        .rd_req        (rd_req),
        .rd_grant      (rd_grant),
        .core_beat     (core_beat),
        .rd_beat_valid (rd_beat_valid)
    );

    ddr_mem_core u_core (
        .clk           (clk),
        .rst           (rst),
        .init_done     (init_done),
        .wr_head       (wr_head),
        .wr_pending    (wr_pending),
        .wr_take       (wr_take),
        .wr_idle       (wr_idle),
        .core_cmd      (core_cmd),
        .rd_req        (rd_req),
        .rd_grant      (rd_grant),
        .core_beat     (core_beat),
        .rd_beat_valid (rd_beat_valid)
    );

endmodule

//--- slave_ddr3_sva.sv
`timescale 1ns/100ps
`include "slave_ddr_defines.svh"

module slave_ddr3_sva (
    input logic                          clk,
    input logic                          rst,
    input logic                          init_done,
    input slave_ddr_pkg::host_cmd_t      wr_cmd,
    input logic                          wr_addr_valid,
    input logic                          wr_addr_ready,
    input logic [`SLAVE_DATA_W-1:0]      wr_data,
    input logic [`SLAVE_DATA_W/8-1:0]    wr_strb,
    input logic                          wr_data_valid,
    input logic                          wr_data_ready,
    input logic                          wr_data_last,
    input slave_ddr_pkg::host_cmd_t      rd_cmd,
    input logic                          rd_addr_valid,
    input logic                          rd_addr_ready,
    input logic [`SLAVE_DATA_W-1:0]      rd_data,
    input logic                          rd_data_last,
    input logic                          rd_data_valid,
    input logic                          rd_data_ready
);

    int unsigned n_wr_addr = 0;
    int unsigned n_wr_data = 0;
    int unsigned n_rd_addr = 0;
    int unsigned n_rd_data = 0;
    int unsigned n_quiet   = 0;
    int unsigned n_init    = 0;
    int unsigned fail_count;

    assign fail_count = n_wr_addr + n_wr_data + n_rd_addr + n_rd_data + n_quiet + n_init;

    wr_addr_hold: assert property (@(posedge clk) disable iff (rst)
        wr_addr_valid && !wr_addr_ready |=> wr_addr_valid && $stable(wr_cmd))
        else begin
            n_wr_addr++;
            $error("wr_cmd dropped or changed while stalled");
        end

    wr_data_hold: assert property (@(posedge clk) disable iff (rst)
        wr_data_valid && !wr_data_ready |=>
            wr_data_valid && $stable({wr_data, wr_strb, wr_data_last}))
        else begin
            n_wr_data++;
            $error("write beat dropped or changed while stalled");
        end

    rd_addr_hold: assert property (@(posedge clk) disable iff (rst)
        rd_addr_valid && !rd_addr_ready |=> rd_addr_valid && $stable(rd_cmd))
        else begin
            n_rd_addr++;
            $error("rd_cmd dropped or changed while stalled");
        end

    // read data is the one payload the DUT drives
    rd_data_hold: assert property (@(posedge clk) disable iff (rst)
        rd_data_valid && !rd_data_ready |=>
            rd_data_valid && $stable({rd_data, rd_data_last}))
        else begin
            n_rd_data++;
            $error("read beat dropped or changed under back-pressure");
        end

    quiet_in_init: assert property (@(posedge clk) disable iff (rst)
        !init_done |-> !(wr_addr_ready || wr_data_ready || rd_addr_ready || rd_data_valid))
        else begin
            n_quiet++;
            $error("host handshake active before init_done");
        end

    init_sticky: assert property (@(posedge clk) disable iff (rst)
        init_done |=> init_done)
        else begin
            n_init++;
            $error("init_done fell after rising");
        end

endmodule

bind slave_ddr3 slave_ddr3_sva u_sva (.*);

//--- tb_checker.sv
`timescale 1ns/100ps
`include "slave_ddr_defines.svh"

module tb_checker (
    input  logic                          clk,
    input  logic                          rst,
    input  logic                          init_done,
    input  slave_ddr_pkg::host_cmd_t      wr_cmd,
    input  logic                          wr_addr_valid,
    input  logic                          wr_addr_ready,
    input  logic [`SLAVE_DATA_W-1:0]      wr_data,
    input  logic [`SLAVE_DATA_W/8-1:0]    wr_strb,
    input  logic                          wr_data_valid,
    input  logic                          wr_data_ready,
    input  slave_ddr_pkg::host_cmd_t      rd_cmd,
    input  logic                          rd_addr_valid,
    input  logic                          rd_addr_ready,
    input  logic [`SLAVE_DATA_W-1:0]      rd_data,
    input  logic                          rd_data_last,
    input  logic                          rd_data_valid,
    input  logic                          rd_data_ready,
    output int unsigned                   pass_count,
    output int unsigned                   fail_count
);

    localparam int AW         = `MEM_DEPTH_LOG2 + $clog2(`LANES); // host word index bits
    localparam int WIDE_WORDS = 2 ** `MEM_DEPTH_LOG2;

    logic [31:0] ref_mem [2**AW];
    logic [27:0] wr_addr;
    logic [27:0] rd_addr;
    logic [7:0]  rd_left;
    logic        rd_open;
    logic        init_seen;
    int unsigned init_cycles;

    // stored word for a host address with the upper bits wrapped away
    function automatic logic [31:0] expected_word(input logic [27:0] addr);
        return ref_mem[addr[AW-1:0]];
    endfunction

    function automatic logic [31:0] merge_bytes(input logic [31:0] old,
                                                input logic [31:0] data,
                                                input logic [3:0]  strb);
        logic [31:0] res;
        res = old;
        for (int b = 0; b < 4; b++) begin
            if (strb[b]) begin
                res[8*b +: 8] = data[8*b +: 8];
            end
        end
        return res;
    endfunction

    task automatic compare(input string name, input logic [27:0] addr,
                           input logic [31:0] expected, input logic [31:0] actual);
        if (actual === expected) begin
            pass_count++;
        end else begin
            fail_count++;
            $display("CHECK FAILED %s addr %h expected %h actual %h",
                     name, addr, expected, actual);
        end
    endtask

    always @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < 2**AW; i++) begin
                ref_mem[i] = '0;                  // sweep leaves the array at zero
            end
            pass_count  = 0;
            fail_count  = 0;
            wr_addr     = '0;
            rd_addr     = '0;
            rd_left     = '0;
            rd_open     = 1'b0;
            init_seen   = 1'b0;
            init_cycles = 0;
        end else begin
            if (!init_done) begin
                init_cycles++;
                if (wr_addr_ready || wr_data_ready || rd_addr_ready || rd_data_valid) begin
                    fail_count++;
                    $display("host ready or valid went high before init_done at %0t", $time);
                end
            end else if (!init_seen) begin
                init_seen = 1'b1;
                if (init_cycles != WIDE_WORDS) begin
                    fail_count++;
                    $display("init_done rose after %0d cycles instead of %0d",
                             init_cycles, WIDE_WORDS);
                end
            end

            if (wr_addr_valid && wr_addr_ready) begin
                wr_addr = wr_cmd.addr;
            end
            if (wr_data_valid && wr_data_ready) begin
                ref_mem[wr_addr[AW-1:0]] = merge_bytes(expected_word(wr_addr),
                                                       wr_data, wr_strb);
                wr_addr = wr_addr + 1'b1;
            end

            if (rd_addr_valid && rd_addr_ready) begin
                rd_addr = rd_cmd.addr;
                rd_left = rd_cmd.len;
                rd_open = 1'b1;
            end
            if (rd_data_valid && rd_data_ready) begin
                if (!rd_open) begin
                    fail_count++;
                    $display("read beat accepted with no read burst open at %0t", $time);
                end else begin
                    compare("rd_data", rd_addr, expected_word(rd_addr), rd_data);
                    compare("rd_data_last", rd_addr, {31'b0, rd_left == 8'd0},
                            {31'b0, rd_data_last});
                    rd_open = (rd_left != 8'd0);
                    rd_addr = rd_addr + 1'b1;
                    rd_left = rd_left - 1'b1;
                end
            end
        end
    end

endmodule

//--- tb_slave_ddr3.sv
`timescale 1ns/100ps
`include "slave_ddr_defines.svh"

module tb_slave_ddr3;

    localparam int PERIOD = 20;

    logic                         clk = 1'b0;
    logic                         rst;
    logic                         init_done;
    slave_ddr_pkg::host_cmd_t     wr_cmd;
    logic                         wr_addr_valid;
    logic                         wr_addr_ready;
    logic [`SLAVE_DATA_W-1:0]     wr_data;
    logic [`SLAVE_DATA_W/8-1:0]   wr_strb;
    logic                         wr_data_valid;
    logic                         wr_data_ready;
    logic                         wr_data_last;
    slave_ddr_pkg::host_cmd_t     rd_cmd;
    logic                         rd_addr_valid;
    logic                         rd_addr_ready;
    logic [`SLAVE_DATA_W-1:0]     rd_data;
    logic                         rd_data_last;
    logic                         rd_data_valid;
    logic                         rd_data_ready;

    int unsigned chk_pass;
    int unsigned chk_fail;
    int unsigned fails_before = 0;
    int unsigned test_num = 0;
    int unsigned budget = 256;    // cycle allowance that grows with every burst
    int unsigned cycles = 0;
    integer      seed = 32'h40bf;

    always #(PERIOD/2) clk = ~clk;

    slave_ddr3 DUT (.*);

    tb_checker u_checker (
        .*,
        .pass_count (chk_pass),
        .fail_count (chk_fail)
    );

    function automatic logic [31:0] rand32();
        return $random(seed);
    endfunction

    function automatic int unsigned total_fails();
        return chk_fail + DUT.u_sva.fail_count; // checker plus assertion failures
    endfunction

    task automatic add_budget(input logic [7:0] len);
        budget += 4 * (int'(len) + 1) + 50;
    endtask

    task automatic end_test(input string name);
        int unsigned errs;
        errs = total_fails() - fails_before;
        test_num++;
        if (errs == 0) begin
            $display("test %0d %s: ok", test_num, name);
        end else begin
            $display("test %0d %s: %0d errors", test_num, name, errs);
        end
        fails_before = total_fails();
    endtask

    task automatic write_burst(input logic [27:0] addr, input logic [7:0] len,
                               input logic full_strb);
        logic [31:0] rnd;
        add_budget(len);
        @(negedge clk);
        wr_cmd.addr   = addr;
        wr_cmd.len    = len;
        wr_addr_valid = 1'b1;
        while (!wr_addr_ready) @(negedge clk);
        @(negedge clk);                          // address taken at the last posedge
        wr_addr_valid = 1'b0;
        for (int i = 0; i <= int'(len); i++) begin
            rnd           = rand32();
            wr_data       = rand32();
            wr_strb       = full_strb ? 4'hf : rnd[3:0];
            wr_data_last  = (i == int'(len));
            wr_data_valid = 1'b1;
            while (!wr_data_ready) @(negedge clk);
            @(negedge clk);
        end
        wr_data_valid = 1'b0;
        wr_data_last  = 1'b0;
        while (!wr_addr_ready) @(negedge clk);  // last word is in the array
    endtask

    task automatic read_burst(input logic [27:0] addr, input logic [7:0] len,
                              input logic stall);
        logic [31:0] rnd;
        logic        done;
        add_budget(len);
        @(negedge clk);
        rd_cmd.addr   = addr;
        rd_cmd.len    = len;
        rd_addr_valid = 1'b1;
        while (!rd_addr_ready) @(negedge clk);
        @(negedge clk);
        rd_addr_valid = 1'b0;
        done          = 1'b0;
        while (!done) begin
            rnd           = rand32();
            rd_data_ready = !stall || (rnd[1:0] != 2'b00); // about one stall in four
            done          = rd_data_valid && rd_data_ready && rd_data_last;
            @(negedge clk);
        end
        rd_data_ready = 1'b0;
    endtask

    initial begin
        logic [31:0] rnd;
        logic [27:0] addr;
        logic [7:0]  len;
        rst           = 1'b1;
        wr_cmd        = '0;
        wr_addr_valid = 1'b0;
        wr_data       = '0;
        wr_strb       = '0;
        wr_data_valid = 1'b0;
        wr_data_last  = 1'b0;
        rd_cmd        = '0;
        rd_addr_valid = 1'b0;
        rd_data_ready = 1'b0;
        repeat (2) @(negedge clk);
        rst = 1'b0;

        while (!init_done) @(negedge clk);
        read_burst(28'h0300, 8'd15, 1'b0);      // never written
        end_test("init and unwritten memory");

        write_burst(28'h0040, 8'd15, 1'b1);
        read_burst(28'h0040, 8'd15, 1'b0);
        end_test("aligned 16-beat burst");

        for (int lane = 1; lane < 8; lane++) begin
            addr = 28'(256 + lane * 65);         // low bits land on the lane
            len  = 8'((lane - 1) * 4);           // odd beat counts from 1 to 25
            write_burst(addr, len, 1'b1);
            read_burst(addr - 28'(lane + 8), 8'(int'(len) + lane + 16), 1'b0);
        end
        end_test("unaligned starts");

        write_burst(28'h0403, 8'd23, 1'b1);
        write_burst(28'h0403, 8'd23, 1'b0);
        read_burst(28'h0400, 8'd31, 1'b0);
        end_test("partial strobes");

        write_burst(28'h0500, 8'd255, 1'b1);
        read_burst(28'h0500, 8'd255, 1'b1);
        end_test("256-beat read, back-pressure");

        for (int n = 0; n < 16; n++) begin
            rnd  = rand32();
            addr = (n == 0) ? 28'h07fb : rnd[27:0]; // first one runs over the top
            rnd  = rand32();
            len  = (n == 0) ? 8'd31 : {2'b00, rnd[5:0]};
            write_burst(addr, len, rnd[31]);
            read_burst(addr - 28'(rnd[11:8]), len + 8'(rnd[20:16]), rnd[30]);
        end
        end_test("random traffic");

        $display("checks passed %0d, failed %0d", chk_pass, total_fails());
        if (total_fails() == 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

    // watchdog counting cycles after reset against the burst budget
    initial begin
        while (cycles <= budget) begin
            @(posedge clk);
            if (!rst) begin
                cycles++;
            end
        end
        $display("timeout after %0d cycles, the DUT stopped making progress", cycles);
        $display("TESTBENCH FAILED");
        $finish;
    end

endmodule

//--- project.f
+incdir+.
slave_ddr_pkg.sv
sync_fifo.sv
ddr3_write.sv
ddr3_read.sv
ddr_mem_core.sv
slave_ddr3.sv
slave_ddr3_sva.sv
tb_checker.sv
tb_slave_ddr3.sv

//--- Makefile
VERILATOR  ?= verilator
LINT_FLAGS  = --lint-only --timing --assert
SIM_FLAGS   = --binary --timing --assert -j 0
RUN_ARGS    = +verilator+error+limit+100
TOP         = tb_slave_ddr3
FILELIST    = project.f
OBJ_DIR     = obj_dir
PASS_MSG    = TESTBENCH PASSED

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(OBJ_DIR)
	@out="$$(./$(OBJ_DIR)/V$(TOP) $(RUN_ARGS) 2>&1)"; \
	echo "$$out"; \
	echo "$$out" | grep -q "^$(PASS_MSG)$$"

clean:
	rm -rf $(OBJ_DIR)
